//--- verilog/prbs_settings.svh
// Global sizing for the PRBS pattern engine
// LFSR and data word width, tap field layout, word count width
`ifndef PRBS_SETTINGS_SVH
`define PRBS_SETTINGS_SVH

// --------------------------------------------------
// Datapath width
// --------------------------------------------------

// LFSR register and data word width
`define PRBS_WIDTH 8

// --------------------------------------------------
// Tap fields and counters
// --------------------------------------------------

// Number of tap fields in a command
`define PRBS_TAP_COUNT 4

// Bits per 1-based tap index, 0 marks an unused field
`define PRBS_TAP_IW 5

// Concatenated tap vector width
`define PRBS_TAPS_W (`PRBS_TAP_COUNT * `PRBS_TAP_IW)

// Word count and error count width
`define PRBS_COUNT_W 16

`endif

//--- verilog/prbs_pkg.sv
// Shared types for the PRBS pattern engine
// Word, tap and count vectors, config command struct, control FSM states
`include "prbs_settings.svh"

package prbs_pkg;

    // --------------------------------------------------
    // Plain vectors
    // --------------------------------------------------

    // One PRBS data word
    typedef logic [`PRBS_WIDTH-1:0] prbs_word_t;

    // Concatenated tap positions, field 0 in the low bits
    typedef logic [`PRBS_TAPS_W-1:0] prbs_taps_t;

    // Word count or error count
    typedef logic [`PRBS_COUNT_W-1:0] prbs_count_t;

    // --------------------------------------------------
    // Config command
    // --------------------------------------------------

    // Seed in the top bits, word count at the bottom
    typedef struct packed {
        prbs_word_t  seed;
        prbs_taps_t  taps;
        prbs_count_t word_count;
    } prbs_cfg_t;

    // --------------------------------------------------
    // Control FSM
    // --------------------------------------------------

    // idle waits for a command, load seeds the LFSR,
    // run streams words, drain empties the skid buffer
    typedef enum logic [1:0] {
        idle  = 2'd0,
        load  = 2'd1,
        run   = 2'd2,
        drain = 2'd3
    } prbs_state_t;

endpackage

//--- verilog/shifter_lfsr.sv
// Shift LFSR with XNOR feedback
// Run-time seed and tap list, left shift, seed-wrap compare
`timescale 1ns/100ps

module shifter_lfsr #(
    parameter int WIDTH           = 8,
    parameter int TAP_INDEX_WIDTH = 5,
    parameter int TAP_COUNT       = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // Step or load strobe
    input  logic                                 enable,
    // Load seed instead of stepping, needs enable
    input  logic                                 seed_load,
    input  logic [WIDTH-1:0]                     seed_data,
    // 1-based tap positions, 0 means unused
    input  logic [TAP_COUNT*TAP_INDEX_WIDTH-1:0] taps,
    output logic [WIDTH-1:0]                     lfsr_out,
    // Current state equals the seed
    output logic                                 lfsr_done
);
    // Short alias for the tap field width
    localparam int TIW = TAP_INDEX_WIDTH;

    logic [WIDTH-1:0] tap_mask;
    logic [WIDTH-1:0] lfsr_q;
    logic             feedback;

    // --------------------------------------------------
    // Tap decode
    // --------------------------------------------------

    // Bit b is tapped when any field holds b+1
    // Out of range fields match no bit
    always_comb begin
        tap_mask = '0;
        for (int b = 0; b < WIDTH; b++) begin
            for (int i = 0; i < TAP_COUNT; i++) begin
                if (taps[i*TIW +: TIW] == TIW'(b + 1)) begin
                    tap_mask[b] = 1'b1;
                end
            end
        end
    end

    // XNOR of the tapped bits, enters at bit 0
    assign feedback = ~^(lfsr_q & tap_mask);

    // --------------------------------------------------
    // State register
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= '0;
        end else if (enable) begin
            if (seed_load) begin
                lfsr_q <= seed_data;
            end else begin
                // Left shift
                lfsr_q <= {lfsr_q[WIDTH-2:0], feedback};
            end
        end
    end

    assign lfsr_out = lfsr_q;

    // Back at the seed, a full period has passed
    assign lfsr_done = (lfsr_q == seed_data);

endmodule

//--- verilog/prbs_ctrl.sv
// Control FSM of the PRBS generator
// Config capture, seed load, stepping, word count, done pulse, wrap flag
`timescale 1ns/100ps

module prbs_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    // Config command
    input  logic                  cfg_valid,
    output logic                  cfg_ready,
    input  prbs_pkg::prbs_cfg_t   cfg,
    // Generator LFSR
    output logic                  gen_enable,
    output logic                  gen_seed_load,
    output prbs_pkg::prbs_word_t  gen_seed,
    output prbs_pkg::prbs_taps_t  gen_taps,
    input  logic                  gen_wrap,
    // Skid buffer
    output logic                  push_valid,
    input  logic                  push_ready,
    input  logic                  buf_empty,
    // Status
    output logic                  cfg_start,
    output logic                  gen_done,
    output logic                  wrapped
);
    prbs_pkg::prbs_state_t state;
    prbs_pkg::prbs_state_t state_nxt;
    prbs_pkg::prbs_cfg_t   cfg_q;
    prbs_pkg::prbs_count_t push_cnt;
    logic                  push_fire;
    logic                  last_push;

    // --------------------------------------------------
    // Handshakes
    // --------------------------------------------------

    // Commands only taken while idle
    assign cfg_ready = (state == prbs_pkg::idle);
    assign cfg_start = cfg_valid && cfg_ready;

    // One word per cycle in run, held off by the buffer
    assign push_valid = (state == prbs_pkg::run);
    assign push_fire  = push_valid && push_ready;
    // word_count is nonzero whenever run is entered
    assign last_push  = push_fire && (push_cnt == cfg_q.word_count - 1'b1);

    // LFSR steps only with a push, so the pushed word is the pre-step value
    assign gen_seed_load = (state == prbs_pkg::load);
    assign gen_enable    = gen_seed_load || push_fire;
    assign gen_seed      = cfg_q.seed;
    assign gen_taps      = cfg_q.taps;

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            prbs_pkg::idle: begin
                if (cfg_start) begin
                    state_nxt = prbs_pkg::load;
                end
            end
            prbs_pkg::load: begin
                // Empty run skips straight to drain
                if (cfg_q.word_count == '0) begin
                    state_nxt = prbs_pkg::drain;
                end else begin
                    state_nxt = prbs_pkg::run;
                end
            end
            prbs_pkg::run: begin
                if (last_push) begin
                    state_nxt = prbs_pkg::drain;
                end
            end
            prbs_pkg::drain: begin
                if (buf_empty) begin
                    state_nxt = prbs_pkg::idle;
                end
            end
            default: state_nxt = prbs_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= prbs_pkg::idle;
            push_cnt <= '0;
            gen_done <= 1'b0;
            wrapped  <= 1'b0;
        end else begin
            state    <= state_nxt;
            // Single cycle, state is idle by then
            gen_done <= (state == prbs_pkg::drain) && buf_empty;
            if (cfg_start) begin
                push_cnt <= '0;
            end else if (push_fire) begin
                push_cnt <= push_cnt + 1'b1;
            end
            // Sticky, word 0 is the seed itself and does not count
            if (cfg_start) begin
                wrapped <= 1'b0;
            end else if (push_fire && (push_cnt != '0) && gen_wrap) begin
                wrapped <= 1'b1;
            end
        end
    end

    // Command held for the whole run
    always_ff @(posedge clk) begin
        if (cfg_start) begin
            cfg_q <= cfg;
        end
    end

    // No push beyond the commanded word count
    push_within_count: assert property (
        @(posedge clk) disable iff (!rst_n)
        push_fire |-> (push_cnt < cfg_q.word_count)
    ) else $error("push beyond the commanded word count");

endmodule

//--- verilog/prbs_skid_buffer.sv
// Two-entry output skid buffer for the generator stream
// In-order release, stable data under back-pressure, empty flag
`timescale 1ns/100ps

module prbs_skid_buffer (
    input  logic                 clk,
    input  logic                 rst_n,
    // From the controller
    input  logic                 push_valid,
    output logic                 push_ready,
    input  prbs_pkg::prbs_word_t push_data,
    // Transmit port
    output logic                 tx_valid,
    input  logic                 tx_ready,
    output prbs_pkg::prbs_word_t tx_data,
    output logic                 empty
);
    // Head entry drives the port, tail catches one more word
    prbs_pkg::prbs_word_t head_q;
    prbs_pkg::prbs_word_t tail_q;
    logic [1:0]           count;
    logic                 push;
    logic                 pop;

    assign push_ready = (count != 2'd2);
    assign tx_valid   = (count != 2'd0);
    assign tx_data    = head_q;
    assign empty      = (count == 2'd0);

    assign push = push_valid && push_ready;
    assign pop  = tx_valid && tx_ready;

    // Occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= 2'd0;
        end else if (push && !pop) begin
            count <= count + 2'd1;
        end else if (pop && !push) begin
            count <= count - 2'd1;
        end
    end

    // Data moves only on push or pop
    always_ff @(posedge clk) begin
        if (pop) begin
            // Tail advances, or a new word lands in the freed head
            if (count == 2'd2) begin
                head_q <= tail_q;
            end else begin
                head_q <= push_data;
            end
        end else if (push) begin
            if (count == 2'd0) begin
                head_q <= push_data;
            end else begin
                tail_q <= push_data;
            end
        end
    end

    // A held word stays put until the port takes it
    tx_stable_under_bp: assert property (
        @(posedge clk) disable iff (!rst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data)
    ) else $error("tx word changed before it was taken");

endmodule

//--- verilog/prbs_checker.sv
// Self-synchronising PRBS receive checker
// Seeds its LFSR from the first word, counts mismatching words
`timescale 1ns/100ps
`include "prbs_settings.svh"

module prbs_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    // New command, clears sync and count
    input  logic                  start,
    input  prbs_pkg::prbs_taps_t  taps,
    // Received stream, always accepted
    input  logic                  rx_valid,
    input  prbs_pkg::prbs_word_t  rx_data,
    output logic                  rx_synced,
    output prbs_pkg::prbs_count_t err_count
);
    prbs_pkg::prbs_word_t predict;
    prbs_pkg::prbs_word_t rx_q;
    logic                 lfsr_en;
    logic                 lfsr_load;
    logic                 cmp_q;
    logic                 mismatch;

    // --------------------------------------------------
    // Local LFSR
    // --------------------------------------------------

    // First word loads, each later word steps to its own prediction
    assign lfsr_en   = rx_valid && !start;
    assign lfsr_load = !rx_synced;

    shifter_lfsr #(
        .WIDTH           (`PRBS_WIDTH),
        .TAP_INDEX_WIDTH (`PRBS_TAP_IW),
        .TAP_COUNT       (`PRBS_TAP_COUNT)
    ) u_chk_lfsr (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (lfsr_en),
        .seed_load (lfsr_load),
        .seed_data (rx_data),
        .taps      (taps),
        .lfsr_out  (predict),
        .lfsr_done ()
    );

    // --------------------------------------------------
    // Compare and count
    // --------------------------------------------------

    // A later word waits one cycle for the stepped prediction
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            rx_q <= rx_data;
        end
    end

    assign mismatch = cmp_q && (rx_q != predict);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_synced <= 1'b0;
            cmp_q     <= 1'b0;
            err_count <= '0;
        end else if (start) begin
            rx_synced <= 1'b0;
            cmp_q     <= 1'b0;
            err_count <= '0;
        end else begin
            if (rx_valid) begin
                rx_synced <= 1'b1;
            end
            // The seeding word is never compared
            cmp_q <= rx_valid && rx_synced;
            // Saturates at all ones
            if (mismatch && (err_count != '1)) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

    // Count only moves up between commands
    err_monotonic: assert property (
        @(posedge clk) disable iff (!rst_n)
        !start |=> (err_count >= $past(err_count))
    ) else $error("err_count decreased without start");

endmodule

//--- verilog/prbs_engine.sv
// PRBS pattern engine top level
// Controller, generator LFSR, output skid buffer, receive checker
`timescale 1ns/100ps
`include "prbs_settings.svh"

module prbs_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    // Config command
    input  logic                  cfg_valid,
    output logic                  cfg_ready,
    input  prbs_pkg::prbs_cfg_t   cfg,
    // Transmit stream
    output logic                  tx_valid,
    input  logic                  tx_ready,
    output prbs_pkg::prbs_word_t  tx_data,
    // Receive stream
    input  logic                  rx_valid,
    input  prbs_pkg::prbs_word_t  rx_data,
    // Status
    output logic                  gen_done,
    output logic                  wrapped,
    output logic                  rx_synced,
    output prbs_pkg::prbs_count_t err_count
);
    logic                 cfg_start;
    logic                 gen_enable;
    logic                 gen_seed_load;
    prbs_pkg::prbs_word_t gen_seed;
    prbs_pkg::prbs_taps_t gen_taps;
    prbs_pkg::prbs_word_t gen_word;
    logic                 gen_wrap;
    logic                 push_valid;
    logic                 push_ready;
    logic                 buf_empty;

    prbs_ctrl u_prbs_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_valid     (cfg_valid),
        .cfg_ready     (cfg_ready),
        .cfg           (cfg),
        .gen_enable    (gen_enable),
        .gen_seed_load (gen_seed_load),
        .gen_seed      (gen_seed),
        .gen_taps      (gen_taps),
        .gen_wrap      (gen_wrap),
        .push_valid    (push_valid),
        .push_ready    (push_ready),
        .buf_empty     (buf_empty),
        .cfg_start     (cfg_start),
        .gen_done      (gen_done),
        .wrapped       (wrapped)
    );

    // Generator, its output is the word being pushed
    shifter_lfsr #(
        .WIDTH           (`PRBS_WIDTH),
        .TAP_INDEX_WIDTH (`PRBS_TAP_IW),
        .TAP_COUNT       (`PRBS_TAP_COUNT)
    ) u_gen_lfsr (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (gen_enable),
        .seed_load (gen_seed_load),
        .seed_data (gen_seed),
        .taps      (gen_taps),
        .lfsr_out  (gen_word),
        .lfsr_done (gen_wrap)
    );

    prbs_skid_buffer u_prbs_skid_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .push_data  (gen_word),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .tx_data    (tx_data),
        .empty      (buf_empty)
    );

    // Checker shares the tap set of the running command
    prbs_checker u_prbs_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (cfg_start),
        .taps      (gen_taps),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_synced (rx_synced),
        .err_count (err_count)
    );

endmodule

//--- tb/prbs_engine_tb.sv
// Testbench for the PRBS pattern engine
// Row table of commands, reference sequence model, tx to rx loopback
// with bit 0 error injection, random tx back-pressure, status checks
`timescale 1ns/100ps
`include "prbs_settings.svh"

module prbs_engine_tb;

    // One row of the stimulus table
    typedef struct packed {
        prbs_pkg::prbs_word_t  seed;
        prbs_pkg::prbs_taps_t  taps;
        prbs_pkg::prbs_count_t word_count;
        logic [7:0]            bp_pct;
        logic [15:0]           inj_first;
        logic [3:0]            inj_count;
        logic [1:0]            exp_wrap;
        prbs_pkg::prbs_count_t exp_err;
    } test_row_t;

    localparam int num_rows    = 8;
    localparam int max_words   = 512;
    localparam int inj_stride  = 7;
    localparam int cfg_timeout = 1000;
    // Expected wrap flag taken from the model
    localparam logic [1:0] wrap_model = 2'd2;
    // Field 0 in the low bits, 8,6,5,4 and 8,7
    localparam prbs_pkg::prbs_taps_t taps_max   = {5'd4, 5'd5, 5'd6, 5'd8};
    localparam prbs_pkg::prbs_taps_t taps_short = {5'd0, 5'd0, 5'd7, 5'd8};

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  cfg_valid;
    logic                  cfg_ready;
    prbs_pkg::prbs_cfg_t   cfg;
    logic                  tx_valid;
    logic                  tx_ready = 1'b0;
    prbs_pkg::prbs_word_t  tx_data;
    logic                  rx_valid = 1'b0;
    prbs_pkg::prbs_word_t  rx_data = '0;
    logic                  gen_done;
    logic                  wrapped;
    logic                  rx_synced;
    prbs_pkg::prbs_count_t err_count;

    test_row_t            rows [0:num_rows-1];
    prbs_pkg::prbs_word_t exp_words [0:max_words-1];
    logic                 exp_wrap_model;
    int                   exp_len = 0;
    int                   tx_total = 0;
    int                   row_base = 0;
    int                   word_idx;
    int unsigned          bp_pct = 0;
    int                   inj_first = 0;
    int                   inj_count = 0;
    int                   errors = 0;
    int                   mon_errors = 0;
    logic                 run_active = 1'b0;

    prbs_engine u_prbs_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready),
        .cfg       (cfg),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .tx_data   (tx_data),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .gen_done  (gen_done),
        .wrapped   (wrapped),
        .rx_synced (rx_synced),
        .err_count (err_count)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    // Word 0 is the seed, then shift left with XNOR of tapped bits at bit 0
    task automatic build_expected(input prbs_pkg::prbs_word_t seed,
                                  input prbs_pkg::prbs_taps_t taps,
                                  input prbs_pkg::prbs_count_t count);
        prbs_pkg::prbs_word_t  mask;
        prbs_pkg::prbs_word_t  w;
        logic [`PRBS_TAP_IW-1:0] t;
        mask = '0;
        for (int k = 0; k < `PRBS_TAP_COUNT; k++) begin
            t = taps[k*`PRBS_TAP_IW +: `PRBS_TAP_IW];
            // Nonzero 1-based positions only
            if ((t != '0) && (int'(t) <= `PRBS_WIDTH)) begin
                mask[int'(t) - 1] = 1'b1;
            end
        end
        w = seed;
        exp_wrap_model = 1'b0;
        for (int i = 0; (i < int'(count)) && (i < max_words); i++) begin
            exp_words[i] = w;
            // First repeat of the seed after word 0
            if ((i > 0) && (w == seed)) begin
                exp_wrap_model = 1'b1;
            end
            w = {w[`PRBS_WIDTH-2:0], ~^(w & mask)};
        end
        exp_len = int'(count);
    endtask

    // Word index picked for a bit 0 flip
    function automatic bit inject_here(input int idx);
        int off;
        off = idx - inj_first;
        if ((inj_count == 0) || (off < 0)) begin
            return 1'b0;
        end
        return ((off % inj_stride) == 0) && ((off / inj_stride) < inj_count);
    endfunction

    // --------------------------------------------------
    // Stream side: back-pressure, loopback, tx monitor
    // --------------------------------------------------

    // Random tx back-pressure, one draw per cycle
    initial begin
        void'($urandom(32'hb69be8dc));
        forever begin
            @(posedge clk);
            tx_ready <= (($urandom % 100) >= bp_pct);
        end
    end

    always @(posedge clk) begin
        rx_valid <= 1'b0;
        if (rst_n) begin
            // Run window from acceptance to the done pulse
            if (cfg_valid && cfg_ready) begin
                run_active <= 1'b1;
            end else if (gen_done) begin
                run_active <= 1'b0;
            end
            if (run_active && cfg_ready && !gen_done) begin
                mon_errors++;
                $display("cfg_ready went high during a run before gen_done");
            end
            if (tx_valid && tx_ready) begin
                word_idx = tx_total - row_base;
                if (word_idx >= exp_len) begin
                    mon_errors++;
                    $display("extra tx word %0d beyond the word count %0d", word_idx, exp_len);
                end else if (tx_data !== exp_words[word_idx]) begin
                    mon_errors++;
                    $display("mismatch tx_data word %0d: got %h expected %h",
                             word_idx, tx_data, exp_words[word_idx]);
                end
                tx_total <= tx_total + 1;
                // Back to rx one cycle later, optionally corrupted
                rx_valid <= 1'b1;
                rx_data  <= tx_data ^ prbs_pkg::prbs_word_t'(inject_here(word_idx));
            end
        end
    end

    // --------------------------------------------------
    // Handshake waits
    // --------------------------------------------------

    // Holds cfg_valid until the edge where cfg_ready is seen
    task automatic send_cfg(input prbs_pkg::prbs_cfg_t c, output bit ok);
        int n;
        ok = 1'b0;
        n = 0;
        cfg_valid <= 1'b1;
        cfg       <= c;
        while (!ok && (n < cfg_timeout)) begin
            @(posedge clk);
            if (cfg_ready) begin
                ok = 1'b1;
            end
            n++;
        end
        cfg_valid <= 1'b0;
    endtask

    task automatic wait_done(input int limit, output bit ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && (n < limit)) begin
            @(posedge clk);
            if (gen_done) begin
                ok = 1'b1;
            end
            n++;
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        prbs_pkg::prbs_cfg_t cmd;
        logic                want_wrap;
        bit                  ok;
        bit                  aborted;
        int                  err_before;
        int                  row_err;
        int                  rows_bad;
        int                  rows_run;
        rst_n     = 1'b0;
        cfg_valid = 1'b0;
        cfg       = '0;
        aborted   = 1'b0;
        rows_bad  = 0;
        rows_run  = 0;

        // Seed, taps, count, bp %, first injection, injections, wrap, errors
        rows[0] = '{8'h01, taps_max,   16'd40,  8'd0,  16'd0,  4'd0, 2'd0, 16'd0};
        rows[1] = '{8'h01, taps_max,   16'd40,  8'd50, 16'd0,  4'd0, 2'd0, 16'd0};
        rows[2] = '{8'h01, taps_max,   16'd300, 8'd0,  16'd0,  4'd0, 2'd1, 16'd0};
        rows[3] = '{8'h01, taps_max,   16'd100, 8'd20, 16'd0,  4'd0, 2'd0, 16'd0};
        rows[4] = '{8'h5a, taps_short, 16'd300, 8'd0,  16'd0,  4'd0, wrap_model, 16'd0};
        rows[5] = '{8'h01, taps_max,   16'd60,  8'd30, 16'd10, 4'd1, 2'd0, 16'd1};
        rows[6] = '{8'hc3, taps_max,   16'd80,  8'd50, 16'd5,  4'd3, 2'd0, 16'd3};
        // Empty run, straight to drain
        rows[7] = '{8'h01, taps_max,   16'd0,   8'd0,  16'd0,  4'd0, 2'd0, 16'd0};

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        for (int r = 0; r < num_rows; r++) begin
            err_before = errors + mon_errors;
            build_expected(rows[r].seed, rows[r].taps, rows[r].word_count);
            if (rows[r].exp_wrap == wrap_model) begin
                want_wrap = exp_wrap_model;
            end else begin
                want_wrap = rows[r].exp_wrap[0];
            end
            row_base  = tx_total;
            bp_pct    <= int'(rows[r].bp_pct);
            inj_first = int'(rows[r].inj_first);
            inj_count = int'(rows[r].inj_count);

            cmd.seed       = rows[r].seed;
            cmd.taps       = rows[r].taps;
            cmd.word_count = rows[r].word_count;
            send_cfg(cmd, ok);
            if (!ok) begin
                errors++;
                aborted = 1'b1;
                $display("timeout waiting for cfg_ready in row %0d", r);
                break;
            end

            // Status cleared by the new command
            @(posedge clk);
            if (wrapped !== 1'b0) begin
                errors++;
                $display("mismatch wrapped after config: got %h expected %h", wrapped, 1'b0);
            end
            if (rx_synced !== 1'b0) begin
                errors++;
                $display("mismatch rx_synced after config: got %h expected %h",
                         rx_synced, 1'b0);
            end
            if (err_count !== '0) begin
                errors++;
                $display("mismatch err_count after config: got %h expected %h",
                         err_count, 16'h0);
            end

            wait_done(20 * int'(rows[r].word_count) + 200, ok);
            if (!ok) begin
                errors++;
                aborted = 1'b1;
                $display("timeout waiting for gen_done in row %0d", r);
                break;
            end

            // Loopback and compare pipeline settle
            repeat (4) @(posedge clk);

            if ((tx_total - row_base) != exp_len) begin
                errors++;
                $display("mismatch tx word count: got %h expected %h",
                         tx_total - row_base, exp_len);
            end
            if (wrapped !== want_wrap) begin
                errors++;
                $display("mismatch wrapped: got %h expected %h", wrapped, want_wrap);
            end
            if (rx_synced !== (rows[r].word_count != '0)) begin
                errors++;
                $display("mismatch rx_synced: got %h expected %h",
                         rx_synced, rows[r].word_count != '0);
            end
            if (err_count !== rows[r].exp_err) begin
                errors++;
                $display("mismatch err_count: got %h expected %h", err_count, rows[r].exp_err);
            end

            row_err = errors + mon_errors - err_before;
            rows_run++;
            if (row_err != 0) begin
                rows_bad++;
            end
            $display("row %0d seed %h words %0d bp %0d: %0d errors",
                     r, rows[r].seed, rows[r].word_count, rows[r].bp_pct, row_err);
        end

        $display("rows run %0d, rows with errors %0d, total errors %0d",
                 rows_run, rows_bad, errors + mon_errors);
        if ((errors + mon_errors == 0) && !aborted) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- prbs_engine.f
+incdir+verilog
verilog/prbs_pkg.sv
verilog/shifter_lfsr.sv
verilog/prbs_ctrl.sv
verilog/prbs_skid_buffer.sv
verilog/prbs_checker.sv
verilog/prbs_engine.sv
tb/prbs_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the PRBS engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f prbs_engine.f \
    --top-module prbs_engine_tb \
    -o sim_prbs_engine

./obj_dir/sim_prbs_engine | tee sim.log

if grep -qx "Test passed" sim.log; then
    echo "simulation ok"
    exit 0
else
    echo "simulation reported failure"
    exit 1
fi
